// File: hist_pkg.sv
// shared constants for the histogrammer; the geometry values here are also reported on the bus
`default_nettype none

package hist_pkg;

    localparam logic [7:0] VERSION = 8'd1;
    localparam int REG_SIZE = 8;

    // block address is {ccol, qrow}
    localparam int CCOL_WIDTH = 6;
    localparam int QROW_WIDTH = 8;
    localparam int NUM_CCOL = 56;
    localparam int MEM_ADDR_WIDTH = 14;

    localparam int PIXELS_PER_BLOCK = 16;
    localparam int PIXEL_ADDR_WIDTH = 4;
    localparam int PIXEL_BITS = 8;
    localparam int BLOCK_BITS = 128;

    // bit 63 flags a new stream
    localparam int FRAME_BITS = 64;
    localparam int PAYLOAD_BITS = 63;
    localparam int WINDOW_BITS = 51;

    localparam int TAG_BITS = 8;
    localparam int INNER_TAG_BITS = 11;
    localparam int EVENT_BASE_BITS = 26;

    typedef enum logic [2:0] {
        processing,
        push_zero,
        push_fifo,
        try_push_fifo,
        push_new_stream,
        idle
    } decoder_state_t;

endpackage

`default_nettype wire

// File: frame_fifo.sv
// 32-deep frame FIFO on BUS_CLK; writes while full and reads while empty are ignored
`default_nettype none

module frame_fifo (
    input  wire                              BUS_CLK,
    input  wire                              RST,
    input  wire                              wr_en,
    input  wire  [hist_pkg::FRAME_BITS-1:0]  wr_data,
    input  wire                              rd_en,
    output logic [hist_pkg::FRAME_BITS-1:0]  rd_data,
    output logic                             full,
    output logic                             empty
);

    localparam int ADDR_WIDTH = 5;

    logic [hist_pkg::FRAME_BITS-1:0] mem [2**ADDR_WIDTH];
    logic [hist_pkg::FRAME_BITS-1:0] swapped;
    logic [ADDR_WIDTH:0]             wr_ptr;
    logic [ADDR_WIDTH:0]             rd_ptr;

    // first received byte lands in the top byte
    always_comb begin
        for (int i = 0; i < hist_pkg::FRAME_BITS / 8; i++) begin
            swapped[8*i +: 8] = wr_data[hist_pkg::FRAME_BITS-8-8*i +: 8];
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (wr_en && !full) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= swapped;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // head word is visible before the pop
    assign rd_data = mem[rd_ptr[ADDR_WIDTH-1:0]];
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH])
                  && (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

endmodule

`default_nettype wire

// File: stream_window.sv
// two-frame window; offset must stay at or below 62 and the longest event fits in 51 bits
`default_nettype none

module stream_window (
    input  wire                              BUS_CLK,
    input  wire                              RST,
    input  wire                              load_zero,
    input  wire                              load_fifo,
    input  wire                              start_stream,
    input  wire  [hist_pkg::FRAME_BITS-1:0]  fifo_data,
    input  wire  [7:0]                       offset,
    input  wire                              new_stream,
    input  wire                              is_last,
    output logic [hist_pkg::CCOL_WIDTH-1:0]  ccol_field,
    output logic [hist_pkg::QROW_WIDTH-1:0]  row_field,
    output logic [hist_pkg::PIXELS_PER_BLOCK-1:0] hitmap_field,
    output logic                             is_last_bit,
    output logic                             is_neighbor_bit,
    output logic                             inner_tag,
    output logic                             end_of_stream
);

    localparam int PAIR_BITS = 2 * hist_pkg::PAYLOAD_BITS;
    localparam int EOS_BITS = 10;

    logic [hist_pkg::PAYLOAD_BITS-1:0] current_frame;
    logic [hist_pkg::PAYLOAD_BITS-1:0] next_frame;
    logic [PAIR_BITS-1:0]              pair;
    logic [hist_pkg::WINDOW_BITS-1:0]  window;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            current_frame <= '0;
            next_frame    <= '0;
        end else if (start_stream) begin
            current_frame <= '0;
            next_frame    <= fifo_data[hist_pkg::PAYLOAD_BITS-1:0];
        end else if (load_fifo) begin
            current_frame <= next_frame;
            next_frame    <= fifo_data[hist_pkg::PAYLOAD_BITS-1:0];
        end else if (load_zero) begin
            current_frame <= next_frame;
            next_frame    <= '0;
        end
    end

    // window bit 50 is the stream bit at the offset
    assign pair   = {current_frame, next_frame};
    assign window = pair[PAIR_BITS-1-offset -: hist_pkg::WINDOW_BITS];

    always_comb begin
        int unsigned start;
        int unsigned body;
        start = hist_pkg::WINDOW_BITS - 1 - (new_stream ? hist_pkg::TAG_BITS : 0);
        // columns 56 and up announce an inner tag to skip
        inner_tag = window[start -: hist_pkg::CCOL_WIDTH] >= hist_pkg::NUM_CCOL;
        if (inner_tag) begin
            start = start - hist_pkg::INNER_TAG_BITS;
        end
        end_of_stream   = (window[start -: EOS_BITS] == '0);
        ccol_field      = window[start -: hist_pkg::CCOL_WIDTH];
        body            = start - (is_last ? hist_pkg::CCOL_WIDTH : 0);
        is_last_bit     = window[body];
        is_neighbor_bit = window[body-1];
        row_field       = window[body-2 -: hist_pkg::QROW_WIDTH];
        hitmap_field    = window[body-2-(is_neighbor_bit ? 0 : hist_pkg::QROW_WIDTH)
                                 -: hist_pkg::PIXELS_PER_BLOCK];
    end

endmodule

`default_nettype wire

// File: window_offset.sv
// bit offset into the current frame; one event never spans more than one frame boundary
`default_nettype none

module window_offset (
    input  wire        BUS_CLK,
    input  wire        RST,
    input  wire        restart,
    input  wire        advance,
    input  wire        new_stream,
    input  wire        is_last,
    input  wire        inner_tag,
    input  wire        is_neighbor,
    output logic [7:0] offset,
    output logic       frame_crossed
);

    logic [7:0] length;
    logic [7:0] sum;

    // event length from the optional fields
    always_comb begin
        length = 8'(hist_pkg::EVENT_BASE_BITS);
        if (is_neighbor) begin
            length = length - 8'(hist_pkg::QROW_WIDTH);
        end
        if (is_last) begin
            length = length + 8'(hist_pkg::CCOL_WIDTH);
        end
        if (new_stream) begin
            length = length + 8'(hist_pkg::TAG_BITS);
        end
        if (inner_tag) begin
            length = length + 8'(hist_pkg::INNER_TAG_BITS);
        end
    end

    assign sum           = offset + length;
    assign frame_crossed = (sum > 8'(hist_pkg::PAYLOAD_BITS - 1));

    always_ff @(posedge BUS_CLK) begin
        if (RST || restart) begin
            offset <= '0;
        end else if (advance) begin
            offset <= frame_crossed ? sum - 8'(hist_pkg::PAYLOAD_BITS) : sum;
        end
    end

endmodule

`default_nettype wire

// File: stream_decoder.sv
// event decoder; it stalls whenever recording is low and waits in try_push_fifo on an empty FIFO
`default_nettype none

module stream_decoder (
    input  wire                                   BUS_CLK,
    input  wire                                   RST,
    input  wire                                   recording,
    input  wire                                   fifo_empty,
    input  wire                                   fifo_next_continues,
    input  wire  [hist_pkg::CCOL_WIDTH-1:0]       ccol_field,
    input  wire  [hist_pkg::QROW_WIDTH-1:0]       row_field,
    input  wire  [hist_pkg::PIXELS_PER_BLOCK-1:0] hitmap_field,
    input  wire                                   is_last_bit,
    input  wire                                   is_neighbor_bit,
    input  wire                                   end_of_stream,
    input  wire                                   frame_crossed,
    output logic                                  fifo_rd,
    output logic                                  load_zero,
    output logic                                  load_fifo,
    output logic                                  start_stream,
    output logic                                  advance,
    output logic                                  restart,
    output logic                                  new_stream,
    output logic                                  is_last,
    output logic                                  event_valid,
    output logic [hist_pkg::CCOL_WIDTH-1:0]       event_ccol,
    output logic [hist_pkg::QROW_WIDTH-1:0]       event_qrow,
    output logic [hist_pkg::PIXELS_PER_BLOCK-1:0] event_hitmap
);

    hist_pkg::decoder_state_t state;
    hist_pkg::decoder_state_t state_next;

    logic [hist_pkg::QROW_WIDTH-1:0] last_row [hist_pkg::NUM_CCOL];
    logic [hist_pkg::CCOL_WIDTH-1:0] last_ccol;
    logic [hist_pkg::CCOL_WIDTH-1:0] col;
    logic [hist_pkg::QROW_WIDTH-1:0] prev_row;
    logic [hist_pkg::QROW_WIDTH-1:0] row;

    // column field only follows an is_last event
    assign col      = is_last ? ccol_field : last_ccol;
    assign prev_row = (col < hist_pkg::NUM_CCOL) ? last_row[col] : '0;
    assign row      = is_neighbor_bit ? prev_row + 1'b1 : row_field;

    always_comb begin
        state_next   = state;
        fifo_rd      = 1'b0;
        load_zero    = 1'b0;
        load_fifo    = 1'b0;
        start_stream = 1'b0;
        advance      = 1'b0;
        restart      = 1'b0;
        if (recording) begin
            case (state)
                hist_pkg::idle: begin
                    if (!fifo_empty) begin
                        state_next = hist_pkg::push_new_stream;
                    end
                end
                hist_pkg::push_new_stream: begin
                    start_stream = 1'b1;
                    fifo_rd      = 1'b1;
                    restart      = 1'b1;
                    state_next   = hist_pkg::try_push_fifo;
                end
                hist_pkg::try_push_fifo: begin
                    if (!fifo_empty) begin
                        // a new-stream head stays queued, the tail is zero padded
                        load_fifo  = fifo_next_continues;
                        fifo_rd    = fifo_next_continues;
                        load_zero  = !fifo_next_continues;
                        state_next = hist_pkg::processing;
                    end
                end
                hist_pkg::push_fifo: begin
                    load_fifo  = 1'b1;
                    fifo_rd    = 1'b1;
                    state_next = hist_pkg::processing;
                end
                hist_pkg::push_zero: begin
                    load_zero  = 1'b1;
                    state_next = hist_pkg::processing;
                end
                hist_pkg::processing: begin
                    if (end_of_stream) begin
                        state_next = hist_pkg::idle;
                    end else begin
                        advance = 1'b1;
                        if (frame_crossed) begin
                            if (fifo_empty) begin
                                state_next = hist_pkg::try_push_fifo;
                            end else if (fifo_next_continues) begin
                                state_next = hist_pkg::push_fifo;
                            end else begin
                                state_next = hist_pkg::push_zero;
                            end
                        end
                    end
                end
                default: state_next = hist_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            state       <= hist_pkg::idle;
            new_stream  <= 1'b1;
            is_last     <= 1'b1;
            last_ccol   <= '0;
            event_valid <= 1'b0;
            for (int i = 0; i < hist_pkg::NUM_CCOL; i++) begin
                last_row[i] <= '0;
            end
        end else begin
            state       <= state_next;
            event_valid <= advance;
            if (start_stream) begin
                new_stream <= 1'b1;
                is_last    <= 1'b1;
            end
            if (advance) begin
                new_stream <= 1'b0;
                is_last    <= is_last_bit;
                last_ccol  <= col;
                if (col < hist_pkg::NUM_CCOL) begin
                    last_row[col] <= row;
                end
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (advance) begin
            event_ccol   <= col;
            event_qrow   <= row;
            event_hitmap <= hitmap_field;
        end
    end

endmodule

`default_nettype wire

// File: hit_histogram.sv
// histogram block memory; bus access needs recording low and ABUS_WIDTH of at least 18
`default_nettype none

module hit_histogram #(
    parameter int ABUS_WIDTH = 32
) (
    input  wire                                   BUS_CLK,
    input  wire                                   RST,
    input  wire                                   recording,
    input  wire  [ABUS_WIDTH-1:0]                 bus_add,
    input  wire  [7:0]                            bus_data_in,
    input  wire                                   bus_rd,
    input  wire                                   bus_wr,
    input  wire                                   event_valid,
    input  wire  [hist_pkg::CCOL_WIDTH-1:0]       event_ccol,
    input  wire  [hist_pkg::QROW_WIDTH-1:0]       event_qrow,
    input  wire  [hist_pkg::PIXELS_PER_BLOCK-1:0] event_hitmap,
    output logic [7:0]                            mem_rd_data,
    output logic [7:0]                            event_count
);

    localparam int BYTE_ADDR_WIDTH = hist_pkg::MEM_ADDR_WIDTH + hist_pkg::PIXEL_ADDR_WIDTH;
    localparam int PB = hist_pkg::PIXEL_BITS;

    logic [hist_pkg::BLOCK_BITS-1:0] mem [2**hist_pkg::MEM_ADDR_WIDTH];

    logic [ABUS_WIDTH-1:0]                 mem_off;
    logic                                  bus_hit;
    logic [hist_pkg::MEM_ADDR_WIDTH-1:0]   rd_addr;
    logic [hist_pkg::BLOCK_BITS-1:0]       rd_q;
    logic [hist_pkg::BLOCK_BITS-1:0]       cur;
    logic                                  fwd;
    logic [hist_pkg::BLOCK_BITS-1:0]       fwd_data;
    logic                                  ev_d;
    logic                                  bus_wr_d;
    logic [hist_pkg::MEM_ADDR_WIDTH-1:0]   addr_d;
    logic [hist_pkg::PIXELS_PER_BLOCK-1:0] hit_d;
    logic [7:0]                            byte_d;
    logic [hist_pkg::PIXEL_ADDR_WIDTH-1:0] pix_d;
    logic                                  wr_en;
    logic [hist_pkg::BLOCK_BITS-1:0]       wr_data;
    logic [hist_pkg::BLOCK_BITS-1:0]       inc;

    initial begin
        for (int i = 0; i < 2**hist_pkg::MEM_ADDR_WIDTH; i++) begin
            mem[i] = '0;
        end
    end

    assign mem_off = bus_add - ABUS_WIDTH'(hist_pkg::REG_SIZE);
    assign bus_hit = !recording && (bus_add >= hist_pkg::REG_SIZE)
                  && ((mem_off >> BYTE_ADDR_WIDTH) == '0);
    assign rd_addr = (bus_hit && (bus_rd || bus_wr))
                   ? mem_off[BYTE_ADDR_WIDTH-1:hist_pkg::PIXEL_ADDR_WIDTH]
                   : {event_ccol, event_qrow};

    always_ff @(posedge BUS_CLK) begin
        rd_q <= mem[rd_addr];
        if (wr_en) begin
            mem[addr_d] <= wr_data;
        end
    end

    // back-to-back events on one block see the block being written
    always_ff @(posedge BUS_CLK) begin
        fwd      <= wr_en && (addr_d == rd_addr);
        fwd_data <= wr_data;
        addr_d   <= rd_addr;
        hit_d    <= event_hitmap;
        byte_d   <= bus_data_in;
        pix_d    <= mem_off[hist_pkg::PIXEL_ADDR_WIDTH-1:0];
    end

    assign cur = fwd ? fwd_data : rd_q;

    always_comb begin
        logic [PB-1:0] px;
        for (int i = 0; i < hist_pkg::PIXELS_PER_BLOCK; i++) begin
            px = cur[i*PB +: PB];
            inc[i*PB +: PB] = (px == '1) ? px : px + PB'(hit_d[i]);
        end
    end

    // a bus write fills the whole block with the byte
    assign wr_en       = bus_wr_d || ev_d;
    assign wr_data     = bus_wr_d ? {hist_pkg::PIXELS_PER_BLOCK{byte_d}} : inc;
    assign mem_rd_data = cur[pix_d*PB +: PB];

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            ev_d        <= 1'b0;
            bus_wr_d    <= 1'b0;
            event_count <= '0;
        end else begin
            ev_d     <= event_valid;
            bus_wr_d <= bus_wr && bus_hit;
            if (event_valid) begin
                event_count <= event_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bus_regs.sv
// register map; reading address 7 gives overflow in bit 7 and recording in bit 6
`default_nettype none

module bus_regs #(
    parameter int ABUS_WIDTH = 32
) (
    input  wire                   BUS_CLK,
    input  wire                   RST,
    input  wire  [ABUS_WIDTH-1:0] bus_add,
    input  wire  [7:0]            bus_data_in,
    input  wire                   bus_rd,
    input  wire                   bus_wr,
    input  wire                   fifo_full,
    input  wire  [7:0]            event_count,
    input  wire  [7:0]            mem_rd_data,
    output logic                  soft_rst,
    output logic                  recording,
    output logic [7:0]            bus_data_out
);

    logic       overflow;
    logic       mem_sel;
    logic [7:0] reg_q;

    assign soft_rst = RST || (bus_wr && (bus_add == '0));

    always_ff @(posedge BUS_CLK) begin
        if (soft_rst) begin
            recording <= 1'b0;
            overflow  <= 1'b0;
            mem_sel   <= 1'b0;
            reg_q     <= '0;
        end else begin
            if (bus_wr && (bus_add == ABUS_WIDTH'(7))) begin
                recording <= bus_data_in[7];
            end
            // sticky until the next soft reset
            if (fifo_full) begin
                overflow <= 1'b1;
            end
            mem_sel <= bus_rd && (bus_add >= hist_pkg::REG_SIZE) && !recording;
            reg_q   <= '0;
            if (bus_rd) begin
                case (bus_add)
                    ABUS_WIDTH'(0): reg_q <= hist_pkg::VERSION;
                    ABUS_WIDTH'(1): reg_q <= event_count;
                    ABUS_WIDTH'(5): reg_q <= 8'(hist_pkg::MEM_ADDR_WIDTH);
                    ABUS_WIDTH'(6): reg_q <= 8'(hist_pkg::REG_SIZE);
                    ABUS_WIDTH'(7): reg_q <= {overflow, recording, 6'b0};
                    default:        reg_q <= '0;
                endcase
            end
        end
    end

    assign bus_data_out = mem_sel ? mem_rd_data : reg_q;

endmodule

`default_nettype wire

// File: hist53b_core.sv
// histogrammer top; the stream is sampled on BUS_CLK and frames arriving while the FIFO is full are lost
`default_nettype none

module hist53b_core #(
    parameter int ABUS_WIDTH = 32
) (
    input  wire                             BUS_CLK,
    input  wire                             RST,
    input  wire  [ABUS_WIDTH-1:0]           bus_add,
    input  wire  [7:0]                      bus_data_in,
    input  wire                             bus_rd,
    input  wire                             bus_wr,
    output logic [7:0]                      bus_data_out,
    input  wire  [hist_pkg::FRAME_BITS-1:0] rx_data,
    input  wire                             rx_valid
);

    logic                                  soft_rst;
    logic                                  recording;
    logic                                  fifo_wr;
    logic                                  fifo_rd;
    logic [hist_pkg::FRAME_BITS-1:0]       fifo_data;
    logic                                  fifo_full;
    logic                                  fifo_empty;
    logic                                  fifo_next_continues;
    logic                                  load_zero;
    logic                                  load_fifo;
    logic                                  start_stream;
    logic                                  advance;
    logic                                  restart;
    logic                                  new_stream;
    logic                                  is_last;
    logic [7:0]                            offset;
    logic                                  frame_crossed;
    logic [hist_pkg::CCOL_WIDTH-1:0]       ccol_field;
    logic [hist_pkg::QROW_WIDTH-1:0]       row_field;
    logic [hist_pkg::PIXELS_PER_BLOCK-1:0] hitmap_field;
    logic                                  is_last_bit;
    logic                                  is_neighbor_bit;
    logic                                  inner_tag;
    logic                                  end_of_stream;
    logic                                  event_valid;
    logic [hist_pkg::CCOL_WIDTH-1:0]       event_ccol;
    logic [hist_pkg::QROW_WIDTH-1:0]       event_qrow;
    logic [hist_pkg::PIXELS_PER_BLOCK-1:0] event_hitmap;
    logic [7:0]                            mem_rd_data;
    logic [7:0]                            event_count;

    assign fifo_wr             = rx_valid && recording && !fifo_full;
    assign fifo_next_continues = !fifo_data[hist_pkg::FRAME_BITS-1];

    frame_fifo i_frame_fifo (
        .BUS_CLK (BUS_CLK),
        .RST     (soft_rst),
        .wr_en   (fifo_wr),
        .wr_data (rx_data),
        .rd_en   (fifo_rd),
        .rd_data (fifo_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    stream_decoder i_stream_decoder (.RST(soft_rst), .*);

    stream_window i_stream_window (.RST(soft_rst), .*);

    window_offset i_window_offset (
        .RST         (soft_rst),
        .is_neighbor (is_neighbor_bit),
        .*
    );

    hit_histogram #(.ABUS_WIDTH(ABUS_WIDTH)) i_hit_histogram (.RST(soft_rst), .*);

    // bus_regs sees the raw reset and makes the soft one
    bus_regs #(.ABUS_WIDTH(ABUS_WIDTH)) i_bus_regs (.*);

endmodule

`default_nettype wire

// File: tb_hist53b.sv
// testbench for hist53b_core; assumes the histogram memory starts cleared and frames are paced slower than decoding
`default_nettype none

module tb_hist53b;

    typedef struct packed {
        logic       first;
        logic [5:0] col;
        logic       nb;
        logic       last;
        logic       itag;
    } ev_t;

    localparam int NUM_EV = 14;
    localparam int MAX_POLLS = 5000;
    localparam int QUIET_POLLS = 8;

    logic        BUS_CLK;
    logic        RST;
    logic [31:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic [7:0]  bus_data_out;
    logic [63:0] rx_data;
    logic        rx_valid;

    logic [31:0] lcg_state;
    logic [7:0]  exp_mem [int];
    logic [7:0]  model_row [56];
    logic [5:0]  model_col;
    logic        model_last;
    int          num_events;
    logic        stream_bits [$];
    logic [63:0] frames [$];

    // first/col/nb/last/itag; col is ignored where the column field is omitted
    ev_t ev_table [NUM_EV] = '{
        '{1'b1, 6'd5,  1'b0, 1'b1, 1'b0},
        '{1'b0, 6'd9,  1'b0, 1'b0, 1'b0},
        '{1'b0, 6'd9,  1'b0, 1'b1, 1'b0},
        '{1'b0, 6'd12, 1'b0, 1'b1, 1'b0},
        '{1'b0, 6'd20, 1'b0, 1'b1, 1'b1},
        '{1'b1, 6'd12, 1'b1, 1'b1, 1'b0},
        '{1'b0, 6'd12, 1'b1, 1'b0, 1'b0},
        '{1'b0, 6'd12, 1'b1, 1'b1, 1'b0},
        '{1'b0, 6'd33, 1'b0, 1'b0, 1'b1},
        '{1'b0, 6'd33, 1'b1, 1'b0, 1'b0},
        '{1'b0, 6'd33, 1'b0, 1'b1, 1'b0},
        '{1'b1, 6'd55, 1'b0, 1'b0, 1'b0},
        '{1'b0, 6'd55, 1'b1, 1'b1, 1'b0},
        '{1'b0, 6'd1,  1'b0, 1'b1, 1'b1}
    };

    hist53b_core uut (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #50 BUS_CLK = ~BUS_CLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // first stream byte goes in the top byte after the FIFO reversal
    function automatic logic [63:0] byte_swap(input logic [63:0] f);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = f[56-8*i +: 8];
        end
        return r;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            fail_now($sformatf("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic bus_write(input int addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        #10;
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(posedge BUS_CLK);
        #10;
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input int addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        #10;
        bus_add = addr;
        bus_rd  = 1'b1;
        @(posedge BUS_CLK);
        #10;
        bus_rd = 1'b0;
        data   = bus_data_out;
    endtask

    task automatic soft_reset();
        bus_write(0, 8'h00);
        foreach (model_row[i]) begin
            model_row[i] = '0;
        end
        model_col  = '0;
        num_events = 0;
    endtask

    task automatic put_bits(input logic [15:0] v, input int w);
        for (int b = w - 1; b >= 0; b--) begin
            stream_bits.push_back(v[b]);
        end
    endtask

    // cut the stream into 63-bit payloads and flag only the first frame
    task automatic close_stream();
        int n;
        logic [63:0] f;
        n = (stream_bits.size() + 62) / 63;
        for (int k = 0; k < n; k++) begin
            f = '0;
            f[63] = (k == 0);
            for (int j = 0; j < 63; j++) begin
                if (k * 63 + j < stream_bits.size()) begin
                    f[62-j] = stream_bits[k*63+j];
                end
            end
            frames.push_back(f);
        end
        stream_bits.delete();
    endtask

    // encode one event and add its hits to the expected counts
    task automatic add_event(input ev_t e, input logic [7:0] row, input logic [15:0] hm_in);
        logic [5:0]  c;
        logic [7:0]  r;
        logic [15:0] hm;
        int          key;
        hm = hm_in;
        if (e.first) begin
            if (stream_bits.size() > 0) begin
                close_stream();
            end
            put_bits(16'h3c, 8);
            model_last = 1'b1;
        end
        // three leading ones would look like an inner tag
        if (!model_last && e.last && e.nb) begin
            hm[15] = 1'b0;
        end
        if (e.itag) begin
            put_bits(16'h700, 11);
        end
        if (model_last) begin
            put_bits(16'(e.col), 6);
            c = e.col;
        end else begin
            c = model_col;
        end
        put_bits(16'(e.last), 1);
        put_bits(16'(e.nb), 1);
        if (e.nb) begin
            r = model_row[c] + 8'd1;
        end else begin
            r = row;
            put_bits(16'(row), 8);
        end
        put_bits(hm, 16);
        model_row[c] = r;
        model_col    = c;
        model_last   = e.last;
        num_events++;
        for (int p = 0; p < 16; p++) begin
            key = (int'(c) << 12) | (int'(r) << 4) | p;
            if (!exp_mem.exists(key)) begin
                exp_mem[key] = 8'h00;
            end
            if (hm[p] && exp_mem[key] != 8'hff) begin
                exp_mem[key] = exp_mem[key] + 8'd1;
            end
        end
    endtask

    task automatic send_frames();
        while (frames.size() > 0) begin
            @(posedge BUS_CLK);
            #10;
            rx_data  = byte_swap(frames.pop_front());
            rx_valid = 1'b1;
            @(posedge BUS_CLK);
            #10;
            rx_valid = 1'b0;
            repeat (6) @(posedge BUS_CLK);
        end
    endtask

    // decoding is over once the event counter holds still
    task automatic wait_count_settled();
        logic [7:0] v;
        logic [7:0] prev;
        int stable;
        int polls;
        stable = 0;
        polls  = 0;
        bus_read(1, prev);
        while (stable < QUIET_POLLS) begin
            polls++;
            if (polls > MAX_POLLS) begin
                fail_now("Timed out waiting for the event counter to settle");
            end
            bus_read(1, v);
            if (v === prev) begin
                stable++;
            end else begin
                stable = 0;
                prev   = v;
            end
        end
    endtask

    task automatic record_and_check();
        logic [7:0] v;
        close_stream();
        // new-stream frame closes the last stream
        frames.push_back(64'h8000_0000_0000_0000);
        bus_write(7, 8'h80);
        send_frames();
        wait_count_settled();
        bus_read(1, v);
        check_byte("event_count", v, 8'(num_events));
        bus_write(7, 8'h00);
        foreach (exp_mem[k]) begin
            bus_read(8 + k, v);
            check_byte($sformatf("mem[0x%05h]", k), v, exp_mem[k]);
        end
    endtask

    initial begin
        logic [7:0]  v;
        logic [31:0] rnd;
        ev_t         rep;
        lcg_state   = 32'h395a_2785;
        RST         = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        rx_data     = '0;
        rx_valid    = 1'b0;
        model_last  = 1'b1;
        repeat (8) @(posedge BUS_CLK);
        #10;
        RST = 1'b0;
        soft_reset();

        bus_read(0, v);
        check_byte("version", v, 8'h01);
        bus_read(5, v);
        check_byte("mem_addr_width", v, 8'h0e);
        bus_read(6, v);
        check_byte("reg_size", v, 8'h08);
        bus_read(7, v);
        check_byte("status", v, 8'h00);

        // block write with recording off
        bus_write(8 + ((3 << 12) | (250 << 4) | 7), 8'h5a);
        for (int p = 0; p < 16; p++) begin
            exp_mem[(3 << 12) | (250 << 4) | p] = 8'h5a;
        end
        foreach (exp_mem[k]) begin
            bus_read(8 + k, v);
            check_byte($sformatf("mem[0x%05h]", k), v, exp_mem[k]);
        end

        // event table with neighbors, inner tags and multi-frame streams
        soft_reset();
        for (int i = 0; i < NUM_EV; i++) begin
            rnd = lcg_next();
            add_event(ev_table[i], 8'(1 + (rnd >> 8) % 127), 16'(lcg_next() >> 12));
        end
        record_and_check();

        // saturation
        soft_reset();
        rep = '{1'b1, 6'd40, 1'b0, 1'b1, 1'b0};
        for (int i = 0; i < 300; i++) begin
            add_event(rep, 8'd77, 16'ha5c3);
            rep.first = 1'b0;
        end
        record_and_check();

        // overflow and its clearing by soft reset along with the event counter
        soft_reset();
        bus_write(7, 8'h80);
        for (int i = 0; i < 64; i++) begin
            @(posedge BUS_CLK);
            #10;
            rx_data  = byte_swap(64'h8000_0000_0000_0000);
            rx_valid = 1'b1;
        end
        @(posedge BUS_CLK);
        #10;
        rx_valid = 1'b0;
        bus_read(7, v);
        check_byte("status", v, 8'hc0);
        bus_write(0, 8'h00);
        bus_read(7, v);
        check_byte("status", v, 8'h00);
        bus_read(1, v);
        check_byte("event_count", v, 8'h00);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hist_pkg.sv
frame_fifo.sv
stream_window.sv
window_offset.sv
stream_decoder.sv
hit_histogram.sv
bus_regs.sv
hist53b_core.sv
tb_hist53b.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hist53b
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= sources.f
VFLAGS    ?= --binary

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
